/* all.f */
core_pkg.sv
dma_bridge.sv
reset_sequencer.sv
activity_led.sv
audio_mixer.sv
word_memory.sv
emu_top.sv
tb_emu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_emu_top -f all.f

output=$(./obj_dir/Vtb_emu_top)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
	exit 0
fi
exit 1

/* tb_emu_top.sv */
module tb_emu_top;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int LED_HOLD    = 20;
	localparam int MEM_WORDS   = 256;
	localparam int RESET_PULSE = 8;
	localparam int DMA_TIMEOUT = 100;
	localparam int NUM_WORDS   = 16;

	logic    clk_sys;
	logic    reset;
	status_t status;
	logic [1:0] buttons;
	logic    ps2_reset_n;
	logic    dma_rd;
	logic    dma_wr;
	addr_t   dma_addr;
	word_t   dma_dout;
	logic    dma_device;
	word_t   dma_din;
	logic    dma_wait;
	sample_t sb_left;
	sample_t sb_right;
	logic    speaker_enable;
	logic    speaker_out;
	logic    sys_reset;
	logic    cpu_reset;
	logic    led_disk;
	logic    led_user;
	sample_t audio_left;
	sample_t audio_right;

	integer seed;
	int     checks;
	int     errors;
	int     test_errors;
	word_t  model [MEM_WORDS];
	int     idx_list [NUM_WORDS];
	bit     disk_seen;
	bit     user_seen;

	emu_top #(
		.LED_HOLD (LED_HOLD)
	) uut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.status         (status),
		.buttons        (buttons),
		.ps2_reset_n    (ps2_reset_n),
		.dma_rd         (dma_rd),
		.dma_wr         (dma_wr),
		.dma_addr       (dma_addr),
		.dma_dout       (dma_dout),
		.dma_device     (dma_device),
		.dma_din        (dma_din),
		.dma_wait       (dma_wait),
		.sb_left        (sb_left),
		.sb_right       (sb_right),
		.speaker_enable (speaker_enable),
		.speaker_out    (speaker_out),
		.sys_reset      (sys_reset),
		.cpu_reset      (cpu_reset),
		.led_disk       (led_disk),
		.led_user       (led_user),
		.audio_left     (audio_left),
		.audio_right    (audio_right)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// Inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("Check failed at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// LED levels are sampled while the transfer is running
	task automatic await_dma(input string what);
		int cycles;
		cycles = 0;
		while (dma_wait && cycles < DMA_TIMEOUT) begin
			step_cycle();
			cycles++;
			if (led_disk) disk_seen = 1'b1;
			if (led_user) user_seen = 1'b1;
		end
		if (dma_wait) report_timeout({"dma_wait stuck high during ", what});
	endtask

	task automatic host_write(input addr_t addr, input word_t data);
		dma_addr = addr;
		dma_dout = data;
		dma_wr   = 1'b1;
		step_cycle();
		dma_wr = 1'b0;
		compare_value("dma_wait", 32'(dma_wait), 32'd1);
		await_dma("write");
	endtask

	task automatic host_read(input addr_t addr, output word_t data);
		dma_addr = addr;
		dma_rd   = 1'b1;
		step_cycle();
		dma_rd = 1'b0;
		compare_value("dma_wait", 32'(dma_wait), 32'd1);
		await_dma("read");
		data = dma_din;
	endtask

	task automatic leds_dark(input int limit);
		int cycles;
		cycles = 0;
		while ((led_disk || led_user) && cycles < limit) begin
			step_cycle();
			cycles++;
		end
		if (led_disk || led_user) report_timeout("activity LED did not go dark");
	endtask

	// Half of the sample, plus full speaker swing when it is on
	function automatic sample_t expected_mix(input sample_t s, input logic en,
			input logic spk);
		sample_t half;
		half = {s[15], s[15:1]};
		if (en && spk) begin
			return half + 16'sd32767;
		end
		return half;
	endfunction

	initial begin
		word_t   data;
		word_t   rd_data;
		sample_t left;
		sample_t right;
		int      base;
		int      idx;
		int      cycles;

		seed           = 96845;
		checks         = 0;
		errors         = 0;
		test_errors    = 0;
		reset          = 1'b1;
		status         = '0;
		buttons        = '0;
		ps2_reset_n    = 1'b1;
		dma_rd         = 1'b0;
		dma_wr         = 1'b0;
		dma_addr       = '0;
		dma_dout       = '0;
		dma_device     = 1'b0;
		sb_left        = '0;
		sb_right       = '0;
		speaker_enable = 1'b0;
		speaker_out    = 1'b0;
		disk_seen      = 1'b0;
		user_seen      = 1'b0;

		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		compare_value("dma_wait", 32'(dma_wait), 32'd0);
		compare_value("led_disk", 32'(led_disk), 32'd0);
		compare_value("led_user", 32'(led_user), 32'd0);
		repeat (10) begin
			step_cycle();
			compare_value("sys_reset", 32'(sys_reset), 32'd1);
		end
		status[0] = 1'b1;
		step_cycle();
		status[0] = 1'b0;
		cycles = 0;
		while (sys_reset && cycles < 4 * RESET_PULSE) begin
			step_cycle();
			cycles++;
		end
		if (sys_reset) report_timeout("sys_reset stayed high after the host reset pulse");
		compare_value("cpu_reset", 32'(cpu_reset), 32'd0);
		buttons = 2'b10;
		cycles = 0;
		while (!cpu_reset && cycles < 10) begin
			step_cycle();
			cycles++;
		end
		if (!cpu_reset) report_timeout("cpu_reset did not rise on button 1");
		buttons = 2'b00;
		cycles = 0;
		while (cpu_reset && cycles < 10) begin
			step_cycle();
			cycles++;
		end
		if (cpu_reset) report_timeout("cpu_reset did not fall after button release");
		finish_test("reset_sequencing");

		// A stride of 17 keeps the sixteen word indices distinct
		base = $random(seed) & 255;
		for (int i = 0; i < NUM_WORDS; i++) begin
			idx         = (base + i * 17) % MEM_WORDS;
			idx_list[i] = idx;
			data        = word_t'($random(seed));
			host_write(addr_t'(idx) << 2, data);
			model[idx] = data;
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			host_read(addr_t'(idx_list[i]) << 2, rd_data);
			compare_value("dma_din", rd_data, model[idx_list[i]]);
		end
		finish_test("write_read");

		// Read right behind a write, data must already be there
		for (int i = 0; i < 4; i++) begin
			idx  = $random(seed) & (MEM_WORDS - 1);
			data = word_t'($random(seed));
			host_write(addr_t'(idx) << 2, data);
			model[idx] = data;
			host_read(addr_t'(idx) << 2, rd_data);
			compare_value("dma_din", rd_data, model[idx]);
		end
		finish_test("wait_flag");

		leds_dark(LED_HOLD + 10);
		dma_device = 1'b1;
		disk_seen  = 1'b0;
		user_seen  = 1'b0;
		data       = word_t'($random(seed));
		host_write(addr_t'(idx_list[0]) << 2, data);
		model[idx_list[0]] = data;
		require(disk_seen, "led_disk did not light during a disk transfer");
		require(!user_seen, "led_user lit during a disk transfer");
		leds_dark(LED_HOLD + 10);
		dma_device = 1'b0;
		disk_seen  = 1'b0;
		user_seen  = 1'b0;
		host_read(addr_t'(idx_list[0]) << 2, rd_data);
		compare_value("dma_din", rd_data, model[idx_list[0]]);
		require(user_seen, "led_user did not light during a floppy transfer");
		require(!disk_seen, "led_disk lit during a floppy transfer");
		leds_dark(LED_HOLD + 10);
		finish_test("activity_leds");

		for (int i = 0; i < 8; i++) begin
			left  = sample_t'($random(seed));
			right = sample_t'($random(seed));
			for (int combo = 0; combo < 4; combo++) begin
				sb_left        = left;
				sb_right       = right;
				speaker_enable = combo[1];
				speaker_out    = combo[0];
				step_cycle();
				compare_value("audio_left", 32'(audio_left),
					32'(expected_mix(left, combo[1], combo[0])));
				compare_value("audio_right", 32'(audio_right),
					32'(expected_mix(right, combo[1], combo[0])));
			end
		end
		finish_test("audio_mix");

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* emu_top.sv */
module emu_top #(
	parameter int MEM_WORDS    = 256,
	parameter int MEM_WAIT     = 2,
	parameter int READ_LATENCY = 3,
	parameter int RESET_PULSE  = 8,
	parameter int LED_HOLD     = 4500000
) (
	input  logic              clk_sys,
	input  logic              reset,

	// Host control
	input  core_pkg::status_t status,
	input  logic [1:0]        buttons,
	input  logic              ps2_reset_n,

	// Host DMA
	input  logic              dma_rd,
	input  logic              dma_wr,
	input  core_pkg::addr_t   dma_addr,
	input  core_pkg::word_t   dma_dout,
	input  logic              dma_device,
	output core_pkg::word_t   dma_din,
	output logic              dma_wait,

	// Sound sources from the core
	input  core_pkg::sample_t sb_left,
	input  core_pkg::sample_t sb_right,
	input  logic              speaker_enable,
	input  logic              speaker_out,

	output logic              sys_reset,
	output logic              cpu_reset,
	output logic              led_disk,
	output logic              led_user,
	output core_pkg::sample_t audio_left,
	output core_pkg::sample_t audio_right
);
	import core_pkg::*;

	// Bridge to memory
	logic  mem_read;
	logic  mem_write;
	logic  mem_waitrequest;
	logic  mem_readdatavalid;
	addr_t mem_address;
	word_t mem_writedata;
	word_t mem_readdata;

	dma_bridge u_dma_bridge (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dma_rd            (dma_rd),
		.dma_wr            (dma_wr),
		.dma_addr          (dma_addr),
		.dma_dout          (dma_dout),
		.dma_din           (dma_din),
		.dma_wait          (dma_wait),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdatavalid (mem_readdatavalid),
		.mem_readdata      (mem_readdata),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata)
	);

	word_memory #(
		.MEM_WORDS    (MEM_WORDS),
		.MEM_WAIT     (MEM_WAIT),
		.READ_LATENCY (READ_LATENCY)
	) u_word_memory (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdata      (mem_readdata),
		.mem_readdatavalid (mem_readdatavalid)
	);

	reset_sequencer #(
		.RESET_PULSE (RESET_PULSE)
	) u_reset_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.status      (status),
		.buttons     (buttons),
		.ps2_reset_n (ps2_reset_n),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset)
	);

	audio_mixer u_audio_mixer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.sb_left        (sb_left),
		.sb_right       (sb_right),
		.speaker_enable (speaker_enable),
		.speaker_out    (speaker_out),
		.audio_left     (audio_left),
		.audio_right    (audio_right)
	);

	// Wait flag marks traffic, dma_device picks which LED shows it
	activity_led #(
		.LED_HOLD (LED_HOLD)
	) hdd_led (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.activity (dma_device & dma_wait),
		.led      (led_disk)
	);

	activity_led #(
		.LED_HOLD (LED_HOLD)
	) fdd_led (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.activity (~dma_device & dma_wait),
		.led      (led_user)
	);

endmodule

/* word_memory.sv */
module word_memory #(
	parameter int MEM_WORDS    = 256,
	parameter int MEM_WAIT     = 2,
	parameter int READ_LATENCY = 3
) (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            mem_read,
	input  logic            mem_write,
	input  core_pkg::addr_t mem_address,
	input  core_pkg::word_t mem_writedata,
	output logic            mem_waitrequest,
	output core_pkg::word_t mem_readdata,
	output logic            mem_readdatavalid
);
	import core_pkg::*;

	localparam int IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int STALL_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

	word_t              mem [MEM_WORDS];
	addr_t              word_addr;
	logic [IDX_W-1:0]   word_idx;
	logic [STALL_W-1:0] stall_cnt;
	logic               request;
	logic               accept;

	logic [READ_LATENCY-1:0] valid_pipe;
	word_t                   data_pipe [READ_LATENCY];

	// Word index wraps at the memory depth
	assign word_addr = mem_address >> 2;
	assign word_idx  = IDX_W'(word_addr % MEM_WORDS);

	// Every new request is stalled for MEM_WAIT cycles
	assign request         = mem_read | mem_write;
	assign mem_waitrequest = request && (stall_cnt < STALL_W'(MEM_WAIT));
	assign accept          = request && !mem_waitrequest;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stall_cnt <= '0;
		end else if (accept) begin
			stall_cnt <= '0;
		end else if (mem_waitrequest) begin
			stall_cnt <= stall_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && mem_write) begin
			mem[word_idx] <= mem_writedata;
		end
	end

	// Valid bits travel with the data, several reads may be in flight
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= accept & mem_read;
			for (int i = 1; i < READ_LATENCY; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	// Stage 0 samples the array every cycle and only counts when valid
	always_ff @(posedge clk_sys) begin
		data_pipe[0] <= mem[word_idx];
		for (int i = 1; i < READ_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign mem_readdatavalid = valid_pipe[READ_LATENCY-1];
	assign mem_readdata      = data_pipe[READ_LATENCY-1];

endmodule

/* audio_mixer.sv */
module audio_mixer (
	input  logic              clk_sys,
	input  logic              reset,
	input  core_pkg::sample_t sb_left,
	input  core_pkg::sample_t sb_right,
	input  logic              speaker_enable,
	input  logic              speaker_out,
	output core_pkg::sample_t audio_left,
	output core_pkg::sample_t audio_right
);
	import core_pkg::*;

	// Full positive swing of the PC speaker
	localparam sample_t SPEAKER_LEVEL = 16'sh7fff;

	sample_t speaker_level;

	assign speaker_level = (speaker_enable && speaker_out) ? SPEAKER_LEVEL : '0;

	// Halving leaves headroom for the speaker, the sum wraps in 16 bits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_left  <= '0;
			audio_right <= '0;
		end else begin
			audio_left  <= (sb_left >>> 1) + speaker_level;
			audio_right <= (sb_right >>> 1) + speaker_level;
		end
	end

endmodule

/* activity_led.sv */
module activity_led #(
	parameter int LED_HOLD = 4500000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic activity,
	output logic led
);

	localparam int CNT_W = $clog2(LED_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Every active cycle restarts the hold time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (activity) begin
			hold_cnt <= CNT_W'(LED_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign led = (hold_cnt != '0);

endmodule

/* reset_sequencer.sv */
module reset_sequencer #(
	parameter int RESET_PULSE = 8
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  core_pkg::status_t status,
	input  logic [1:0]        buttons,
	input  logic              ps2_reset_n,
	output logic              sys_reset,
	output logic              cpu_reset
);

	logic [1:0]             host_rst_sync;
	logic                   host_rst_prev;
	logic                   host_rst_rise;
	logic [RESET_PULSE-1:0] rst_q;
	logic                   init_done;
	logic                   cpu_rst_q;

	// Host reset request comes from another clock domain
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			host_rst_sync <= '0;
			host_rst_prev <= 1'b0;
		end else begin
			host_rst_sync <= {host_rst_sync[0], status[0]};
			host_rst_prev <= host_rst_sync[1];
		end
	end

	assign host_rst_rise = host_rst_sync[1] & ~host_rst_prev;

	// Each request reloads the stretcher with ones
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rst_q     <= '0;
			init_done <= 1'b0;
		end else if (host_rst_rise) begin
			rst_q     <= '1;
			init_done <= 1'b1;
		end else begin
			rst_q <= rst_q << 1;
		end
	end

	// Reset button, host request or keyboard controller reset line
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_rst_q <= 1'b0;
		end else begin
			cpu_rst_q <= buttons[1] | status[0] | ~ps2_reset_n;
		end
	end

	// System is held in reset until the host asks for the first one
	assign sys_reset = rst_q[RESET_PULSE-1] | ~init_done;
	assign cpu_reset = sys_reset | cpu_rst_q;

endmodule

/* dma_bridge.sv */
module dma_bridge (
	input  logic            clk_sys,
	input  logic            reset,

	// Host single-word DMA port
	input  logic            dma_rd,
	input  logic            dma_wr,
	input  core_pkg::addr_t dma_addr,
	input  core_pkg::word_t dma_dout,
	output core_pkg::word_t dma_din,
	output logic            dma_wait,

	// Memory bus master
	input  logic            mem_waitrequest,
	input  logic            mem_readdatavalid,
	input  core_pkg::word_t mem_readdata,
	output logic            mem_read,
	output logic            mem_write,
	output core_pkg::addr_t mem_address,
	output core_pkg::word_t mem_writedata
);
	import core_pkg::*;

	bridge_state_t state;

	// A host pulse always wins and restarts the sequence
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= idle;
			dma_wait  <= 1'b0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end else if (dma_rd) begin
			state     <= read_issue;
			dma_wait  <= 1'b1;
			mem_read  <= 1'b1;
			mem_write <= 1'b0;
		end else if (dma_wr) begin
			state     <= write_issue;
			dma_wait  <= 1'b1;
			mem_read  <= 1'b0;
			mem_write <= 1'b1;
		end else begin
			case (state)
				read_issue: begin
					// Strobe stays up until the memory takes the request
					if (!mem_waitrequest) begin
						mem_read <= 1'b0;
						state    <= read_data;
					end
				end
				read_data: begin
					if (mem_readdatavalid) begin
						dma_wait <= 1'b0;
						state    <= idle;
					end
				end
				write_issue: begin
					if (!mem_waitrequest) begin
						mem_write <= 1'b0;
						state     <= write_done;
					end
				end
				write_done: begin
					dma_wait <= 1'b0;
					state    <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// Address and write data are latched with the host pulse
	always_ff @(posedge clk_sys) begin
		if (dma_rd || dma_wr) begin
			mem_address   <= dma_addr;
			mem_writedata <= dma_dout;
		end
	end

	// Read data is handed to the host on the edge that drops dma_wait
	always_ff @(posedge clk_sys) begin
		if (state == read_data && mem_readdatavalid) begin
			dma_din <= mem_readdata;
		end
	end

endmodule

/* core_pkg.sv */
package core_pkg;

	// Data word on the host DMA port and on the memory bus
	typedef logic [31:0] word_t;

	// Byte address as issued by the host, the memory decodes bits 2 and up
	typedef logic [31:0] addr_t;

	// Signed audio sample from the sound card and toward the codec
	typedef logic signed [15:0] sample_t;

	// Host status word
	// Bit 0 is the host reset request
	typedef logic [31:0] status_t;

	// DMA bridge sequencing
	typedef enum logic [2:0] {
		idle,
		read_issue,
		read_data,
		write_issue,
		write_done
	} bridge_state_t;

endpackage
